// ==== src.f ====
+incdir+include
verilog/gat_pkg.sv
verilog/gat_sched.sv
verilog/spmm_unit.sv
verilog/dmvm_unit.sv
verilog/aggr_unit.sv
verilog/stage_debugger.sv
verilog/gat_layer_top.sv
sim/clk_gen.sv
sim/tb_gat_layer.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --timing --assert --timescale 1ns/10ps
TOP   := tb_gat_layer
FLIST := src.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim/tb_gat_layer.sv ====
`timescale 1ns/10ps
`include "gat_config.svh"

module tb_gat_layer;
  import gat_pkg::*;

  localparam int   NODES     = 8;
  localparam int   NZ        = `GAT_NUM_NZ;
  localparam int   GRP_N     = `GAT_AGGR_NODES;
  localparam int   TIMEOUT   = 50;
  localparam int   SCORE_LAT = 1;  // negedges after the first one past the last entry.
  localparam col_t DBG_COL   = 4'd9;

  logic   clk;
  logic   rst_n;
  logic   wgt_we_i;
  col_t   wgt_addr_i;
  val_t   wgt_data_i;
  logic   node_start_i;
  logic   nz_vld_i;
  col_t   nz_col_i;
  val_t   nz_val_i;
  col_t   dbg_col_i;
  logic   score_vld_o;
  acc_t   score_o;
  logic   grp_vld_o;
  acc_t   grp_sum_o;
  logic   busy_o;
  flags_t dbg_flags_o;
  cnt_t   dbg_count_o;
  acc_t   dbg_capture_o;

  // stimulus and expected values per node.
  val_t wgt_tab [16];
  col_t col_tab [NODES][NZ];
  val_t val_tab [NODES][NZ];
  int   gap_tab [NODES][NZ];
  acc_t exp_score [NODES];
  acc_t exp_cap_after [NODES];
  acc_t exp_grp [NODES / GRP_N];

  int   errors;
  int   tests;
  int   failed;
  int   errs_at_start;
  logic timeout_hit;

  clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_layer_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .wgt_we_i      (wgt_we_i),
    .wgt_addr_i    (wgt_addr_i),
    .wgt_data_i    (wgt_data_i),
    .node_start_i  (node_start_i),
    .nz_vld_i      (nz_vld_i),
    .nz_col_i      (nz_col_i),
    .nz_val_i      (nz_val_i),
    .dbg_col_i     (dbg_col_i),
    .score_vld_o   (score_vld_o),
    .score_o       (score_o),
    .grp_vld_o     (grp_vld_o),
    .grp_sum_o     (grp_sum_o),
    .busy_o        (busy_o),
    .dbg_flags_o   (dbg_flags_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 8'h%02h, expected 8'h%02h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errs_at_start) begin
      $display("[%0t ns] %s: passed", $time, name);
    end else begin
      failed++;
      $display("[%0t ns] %s: failed", $time, name);
    end
  endtask

  // random table plus the expected results from the layer rules.
  task automatic build_table();
    acc_t acc;
    acc_t cap;
    int   prod;
    for (int c = 0; c < 16; c++) begin
      wgt_tab[c] = val_t'(int'($urandom_range(1023, 1)));
      if (c % 2 == 1) begin
        wgt_tab[c] = -wgt_tab[c];  // odd columns carry negative weights.
      end
    end
    for (int n = 0; n < NODES; n++) begin
      for (int i = 0; i < NZ; i++) begin
        col_tab[n][i] = col_t'($urandom_range(15, 0));
        val_tab[n][i] = val_t'(int'($urandom_range(4095, 0)) - 2048);
        gap_tab[n][i] = int'($urandom_range(2, 0));
        if (n == 2 || n == 4) begin
          if (val_tab[n][i] < 0) begin
            val_tab[n][i] = -val_tab[n][i];
          end
          // node 2 is forced negative and node 4 positive.
          col_tab[n][i] = (n == 2) ? (col_tab[n][i] | 4'h1) : (col_tab[n][i] & 4'he);
        end
      end
    end
    col_tab[5][7] = DBG_COL;
    cap = '0;
    for (int n = 0; n < NODES; n++) begin
      acc = '0;
      for (int i = 0; i < NZ; i++) begin
        prod = int'(val_tab[n][i]) * int'(wgt_tab[col_tab[n][i]]);
        acc  = acc + acc_t'(prod);
        if (col_tab[n][i] == DBG_COL) begin
          cap = acc;
        end
      end
      exp_score[n]     = (acc < 0) ? (acc >>> `GAT_LEAKY_SHIFT) : acc;
      exp_cap_after[n] = cap;
    end
    for (int g = 0; g < NODES / GRP_N; g++) begin
      exp_grp[g] = '0;
      for (int k = 0; k < GRP_N; k++) begin
        exp_grp[g] = exp_grp[g] + exp_score[g * GRP_N + k];
      end
    end
  endtask

  task automatic load_weights();
    for (int c = 0; c < 16; c++) begin
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= col_t'(c);
      wgt_data_i <= wgt_tab[c];
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
  endtask

  task automatic wait_strobe(input logic want_grp, input string name, output int lat);
    logic hit;
    lat = 0;
    hit = 1'b0;
    while (!hit && lat < TIMEOUT) begin
      @(negedge clk);
      lat++;
      hit = want_grp ? grp_vld_o : score_vld_o;
    end
    if (!hit) begin
      $display("timeout: %s never went high within %0d cycles", name, TIMEOUT);
      errors++;
      timeout_hit = 1'b1;
    end
  endtask

  task automatic drive_idle_entries(input int n);
    errs_at_start = errors;
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b0);
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      nz_vld_i <= 1'b1;
      nz_col_i <= DBG_COL;  // a hit here would move the capture.
      nz_val_i <= 16'sh7fff;
    end
    @(posedge clk);
    nz_vld_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_acc("dbg_capture_o", dbg_capture_o, exp_cap_after[n - 1]);
    end_test($sformatf("node %0d idle entries", n));
  endtask

  task automatic run_node(input int n);
    int lat;
    errs_at_start = errors;
    @(posedge clk);
    node_start_i <= 1'b1;
    @(posedge clk);
    node_start_i <= 1'b0;
    for (int i = 0; i < NZ; i++) begin
      if (gap_tab[n][i] > 0) begin
        nz_vld_i <= 1'b0;
        repeat (gap_tab[n][i]) @(posedge clk);
      end
      nz_vld_i <= 1'b1;
      nz_col_i <= col_tab[n][i];
      nz_val_i <= val_tab[n][i];
      @(posedge clk);
    end
    nz_vld_i <= 1'b0;  // this edge samples the last entry.
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b1);  // scheduler sits in score.
    wait_strobe(1'b0, "score_vld_o", lat);
    if (!timeout_hit) begin
      if (lat != SCORE_LAT) begin
        $display("Error at %0t ns: score_vld_o latency is %0d, expected %0d",
                 $time, lat, SCORE_LAT);
        errors++;
      end
      check_acc("score_o", score_o, exp_score[n]);
      end_test($sformatf("node %0d score", n));
      errs_at_start = errors;
      if (n % GRP_N == GRP_N - 1) begin
        wait_strobe(1'b1, "grp_vld_o", lat);
        if (!timeout_hit) begin
          check_cnt("grp_vld_o latency", cnt_t'(lat), cnt_t'(1));
          check_acc("grp_sum_o", grp_sum_o, exp_grp[n / GRP_N]);
          @(negedge clk);
          check_bit("grp_vld_o", grp_vld_o, 1'b0);  // one cycle only.
          end_test($sformatf("group %0d sum", n / GRP_N));
        end
      end else begin
        @(negedge clk);
        check_bit("grp_vld_o", grp_vld_o, 1'b0);
      end
    end
  endtask

  initial begin
    int cyc;
    void'($urandom(32'h01cd_4beb));
    wgt_we_i     = 1'b0;
    wgt_addr_i   = '0;
    wgt_data_i   = '0;
    node_start_i = 1'b0;
    nz_vld_i     = 1'b0;
    nz_col_i     = '0;
    nz_val_i     = '0;
    dbg_col_i    = DBG_COL;
    errors       = 0;
    tests        = 0;
    failed       = 0;
    timeout_hit  = 1'b0;
    build_table();

    cyc = 0;
    while (rst_n !== 1'b1 && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      errors++;
      timeout_hit = 1'b1;
    end

    if (!timeout_hit) begin
      @(negedge clk);
      errs_at_start = errors;
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("score_vld_o", score_vld_o, 1'b0);
      check_bit("grp_vld_o", grp_vld_o, 1'b0);
      check_flags("dbg_flags_o", dbg_flags_o, 8'h00);
      check_cnt("dbg_count_o", dbg_count_o, '0);
      check_acc("dbg_capture_o", dbg_capture_o, '0);
      end_test("reset values");
      load_weights();
      for (int n = 0; n < NODES && !timeout_hit; n++) begin
        if (n % 2 == 1) begin
          drive_idle_entries(n);
        end
        run_node(n);
      end
    end

    if (!timeout_hit) begin
      @(negedge clk);
      errs_at_start = errors;
      check_flags("dbg_flags_o", dbg_flags_o, 8'h1f);
      check_cnt("dbg_count_o", dbg_count_o, cnt_t'(NODES));
      end_test("debug flags and count");
      errs_at_start = errors;
      check_acc("dbg_capture_o", dbg_capture_o, exp_cap_after[NODES - 1]);
      end_test("debug capture");
    end

    $display("tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0 && !timeout_hit) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== verilog/gat_layer_top.sv ====
`timescale 1ns/10ps

module gat_layer_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wgt_we_i,
  input  gat_pkg::col_t   wgt_addr_i,
  input  gat_pkg::val_t   wgt_data_i,
  input  logic            node_start_i,
  input  logic            nz_vld_i,
  input  gat_pkg::col_t   nz_col_i,
  input  gat_pkg::val_t   nz_val_i,
  input  gat_pkg::col_t   dbg_col_i,
  output logic            score_vld_o,
  output gat_pkg::acc_t   score_o,
  output logic            grp_vld_o,
  output gat_pkg::acc_t   grp_sum_o,
  output logic            busy_o,
  output gat_pkg::flags_t dbg_flags_o,
  output gat_pkg::cnt_t   dbg_count_o,
  output gat_pkg::acc_t   dbg_capture_o
);
  import gat_pkg::*;

  logic acc_clr;
  logic mac_en;
  logic score_start;
  logic mac_vld;
  col_t mac_col;
  acc_t acc;

  gat_sched u_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .node_start_i  (node_start_i),
    .nz_vld_i      (nz_vld_i),
    .acc_clr_o     (acc_clr),
    .mac_en_o      (mac_en),
    .score_start_o (score_start),
    .busy_o        (busy_o)
  );

  spmm_unit u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .acc_clr_i  (acc_clr),
    .mac_en_i   (mac_en),
    .nz_col_i   (nz_col_i),
    .nz_val_i   (nz_val_i),
    .acc_o      (acc),
    .mac_vld_o  (mac_vld),
    .mac_col_o  (mac_col)
  );

  dmvm_unit u_dmvm (
    .clk           (clk),
    .rst_n         (rst_n),
    .score_start_i (score_start),
    .acc_i         (acc),
    .score_vld_o   (score_vld_o),
    .score_o       (score_o)
  );

  aggr_unit u_aggr (
    .clk         (clk),
    .rst_n       (rst_n),
    .score_vld_i (score_vld_o),
    .score_i     (score_o),
    .grp_vld_o   (grp_vld_o),
    .grp_sum_o   (grp_sum_o)
  );

  stage_debugger u_dbg (
    .clk           (clk),
    .rst_n         (rst_n),
    .node_start_i  (node_start_i),
    .mac_vld_i     (mac_vld),
    .mac_col_i     (mac_col),
    .acc_i         (acc),
    .score_start_i (score_start),
    .score_vld_i   (score_vld_o),
    .grp_vld_i     (grp_vld_o),
    .dbg_col_i     (dbg_col_i),
    .dbg_flags_o   (dbg_flags_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

endmodule

// ==== verilog/stage_debugger.sv ====
`timescale 1ns/10ps

module stage_debugger (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             node_start_i,
  input  logic             mac_vld_i,
  input  gat_pkg::col_t    mac_col_i,
  input  gat_pkg::acc_t    acc_i,
  input  logic             score_start_i,
  input  logic             score_vld_i,
  input  logic             grp_vld_i,
  input  gat_pkg::col_t    dbg_col_i,
  output gat_pkg::flags_t  dbg_flags_o,
  output gat_pkg::cnt_t    dbg_count_o,
  output gat_pkg::acc_t    dbg_capture_o
);

  logic [4:0] seen_q;
  logic [4:0] strobes;
  logic       col_hit;

  assign strobes = {grp_vld_i, score_vld_i, score_start_i, mac_vld_i, node_start_i};

  // acc_i already holds the sum including the matching entry.
  assign col_hit = mac_vld_i && (mac_col_i == dbg_col_i);

  assign dbg_flags_o = {3'b000, seen_q};

  // flags stay set until reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q <= '0;
    end else begin
      seen_q <= seen_q | strobes;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_count_o <= '0;
    end else if (score_vld_i) begin
      dbg_count_o <= dbg_count_o + 1'b1;  // one per score.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_capture_o <= '0;
    end else if (col_hit) begin
      dbg_capture_o <= acc_i;  // last match wins.
    end
  end

endmodule

// ==== verilog/aggr_unit.sv ====
`timescale 1ns/10ps
`include "gat_config.svh"

module aggr_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          score_vld_i,
  input  gat_pkg::acc_t score_i,
  output logic          grp_vld_o,
  output gat_pkg::acc_t grp_sum_o
);
  import gat_pkg::*;

  localparam int NODE_W = $clog2(`GAT_AGGR_NODES);

  acc_t              run_sum_q;
  logic [NODE_W-1:0] node_cnt_q;
  logic              last_node;

  assign last_node = score_vld_i && (node_cnt_q == NODE_W'(`GAT_AGGR_NODES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_sum_q  <= '0;
      node_cnt_q <= '0;
      grp_vld_o  <= 1'b0;
    end else begin
      grp_vld_o <= last_node;
      if (last_node) begin
        run_sum_q  <= '0;  // next group starts fresh.
        node_cnt_q <= '0;
      end else if (score_vld_i) begin
        run_sum_q  <= run_sum_q + score_i;
        node_cnt_q <= node_cnt_q + 1'b1;
      end
    end
  end

  // held until the next group completes.
  always_ff @(posedge clk) begin
    if (last_node) begin
      grp_sum_o <= run_sum_q + score_i;
    end
  end

endmodule

// ==== verilog/dmvm_unit.sv ====
`timescale 1ns/10ps
`include "gat_config.svh"

module dmvm_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          score_start_i,
  input  gat_pkg::acc_t acc_i,
  output logic          score_vld_o,
  output gat_pkg::acc_t score_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_vld_o <= 1'b0;
    end else begin
      score_vld_o <= score_start_i;
    end
  end

  // leaky rectifier scales negative sums down by a shift.
  always_ff @(posedge clk) begin
    if (score_start_i) begin
      if (acc_i[31]) begin
        score_o <= acc_i >>> `GAT_LEAKY_SHIFT;
      end else begin
        score_o <= acc_i;
      end
    end
  end

endmodule

// ==== verilog/spmm_unit.sv ====
`timescale 1ns/10ps

module spmm_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wgt_we_i,
  input  gat_pkg::col_t wgt_addr_i,
  input  gat_pkg::val_t wgt_data_i,
  input  logic          acc_clr_i,
  input  logic          mac_en_i,
  input  gat_pkg::col_t nz_col_i,
  input  gat_pkg::val_t nz_val_i,
  output gat_pkg::acc_t acc_o,
  output logic          mac_vld_o,
  output gat_pkg::col_t mac_col_o
);
  import gat_pkg::*;

  val_t wgt_q [16];
  acc_t prod;

  // both operands sign-extended before the multiply.
  assign prod = acc_t'(nz_val_i) * acc_t'(wgt_q[nz_col_i]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        wgt_q[i] <= '0;
      end
    end else if (wgt_we_i) begin
      wgt_q[wgt_addr_i] <= wgt_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_o     <= '0;
      mac_vld_o <= 1'b0;
    end else begin
      mac_vld_o <= mac_en_i;
      if (acc_clr_i) begin
        acc_o <= '0;
      end else if (mac_en_i) begin
        acc_o <= acc_o + prod;
      end
    end
  end

  // column of the entry just accumulated.
  always_ff @(posedge clk) begin
    if (mac_en_i) begin
      mac_col_o <= nz_col_i;
    end
  end

  // the scheduler clears only in idle and accumulates only in gather.
  assert property (@(posedge clk) disable iff (!rst_n)
    !(acc_clr_i && mac_en_i))
    else $error("accumulator clear and mac enable overlap.");

endmodule

// ==== verilog/gat_sched.sv ====
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_sched (
  input  logic clk,
  input  logic rst_n,
  input  logic node_start_i,
  input  logic nz_vld_i,
  output logic acc_clr_o,
  output logic mac_en_o,
  output logic score_start_o,
  output logic busy_o
);
  import gat_pkg::*;

  localparam int CNT_W = $clog2(`GAT_NUM_NZ);

  sched_state_t     state_q;
  sched_state_t     state_d;
  logic [CNT_W-1:0] nz_cnt_q;
  logic             last_nz;

  assign acc_clr_o     = (state_q == IDLE) && node_start_i;
  assign mac_en_o      = (state_q == GATHER) && nz_vld_i;  // dropped outside gather.
  assign score_start_o = (state_q == SCORE);
  assign busy_o        = (state_q != IDLE);

  assign last_nz = mac_en_o && (nz_cnt_q == CNT_W'(`GAT_NUM_NZ - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (node_start_i) begin
          state_d = GATHER;
        end
      end
      GATHER: begin
        if (last_nz) begin
          state_d = SCORE;
        end
      end
      SCORE: begin
        state_d = IDLE;  // score start lasts one cycle.
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      nz_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (acc_clr_o) begin
        nz_cnt_q <= '0;
      end else if (mac_en_o) begin
        nz_cnt_q <= last_nz ? '0 : nz_cnt_q + 1'b1;
      end
    end
  end

  // host must wait for busy to drop before the next node.
  assert property (@(posedge clk) disable iff (!rst_n)
    node_start_i |-> state_q == IDLE)
    else $error("node start while scheduler busy.");

endmodule

// ==== verilog/gat_pkg.sv ====
package gat_pkg;

  // weight table index and entry column.
  typedef logic [3:0] col_t;

  typedef logic signed [15:0] val_t;  // entry value and weight.

  // products, accumulator, score and group sum.
  typedef logic signed [31:0] acc_t;

  typedef logic [31:0] cnt_t;
  typedef logic [7:0]  flags_t;

  typedef enum logic [1:0] {
    IDLE,
    GATHER,
    SCORE
  } sched_state_t;

endpackage

// ==== include/gat_config.svh ====
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// sparse entries streamed per node.
`define GAT_NUM_NZ 12

// scores summed into one group result.
`define GAT_AGGR_NODES 4

// arithmetic right shift applied to negative sums.
`define GAT_LEAKY_SHIFT 3

`endif
